/* hw/pkt_classifier_pkg.sv */
package pkt_classifier_pkg;

   // Stream identifier width, 64 interleaved streams
   localparam int STREAM_W = 6;

   // Number of streams follows from the identifier width
   localparam int NUM_STREAMS = 1 << STREAM_W;

   // Category index 0 is NNTP, index 1 is SMTP
   localparam int NUM_CAT = 2;

   // Matcher state is the count of keyword characters matched so far
   // Four bits cover keywords up to 15 characters
   localparam int DFA_STATE_W = 4;

   // Per-category fired-packet counter width
   localparam int COUNT_W = 16;

   // One input cycle on the packet side
   // All strobes are single cycle, there is no back-pressure
   typedef struct packed {
      // Packet start, stream_id is meaningful here
      logic                sop;
      // Packet end
      logic                eop;
      // Byte strobe
      logic                char_vld;
      // Payload byte
      logic [7:0]          char_in;
      // Stream of the packet that starts on this cycle
      logic [STREAM_W-1:0] stream_id;
   } pkt_beat_t;

   // One configuration write into the stream enable table
   // Only legal between eop and the next sop
   typedef struct packed {
      // Write strobe
      logic                we;
      // Stream whose entry is rewritten
      logic [STREAM_W-1:0] stream;
      // One enable bit per category
      logic [NUM_CAT-1:0]  enable;
   } cfg_wr_t;

endpackage

/* hw/keyword_dfa.sv */
`timescale 1ns/1ps

module keyword_dfa #(
   // Number of characters in the keyword
   parameter int                      KEYWORD_LEN = 7,
   // Keyword text, first character in the top byte
   parameter logic [8*KEYWORD_LEN-1:0] KEYWORD    = "ARTICLE"
) (
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic [7:0]                                char_in,
   input  logic                                      char_vld,
   input  logic [pkt_classifier_pkg::DFA_STATE_W-1:0] state_in,
   input  logic                                      state_in_vld,
   output logic [pkt_classifier_pkg::DFA_STATE_W-1:0] state_out,
   output logic                                      accept
);

   typedef logic [pkt_classifier_pkg::DFA_STATE_W-1:0] dfa_state_t;

   // State value of the last keyword character
   localparam dfa_state_t LAST_IDX = dfa_state_t'(KEYWORD_LEN - 1);

   // Matched length so far
   dfa_state_t state;

   // Next character expected
   logic [7:0] next_char;
   // First character, used to restart on a mismatch
   logic [7:0] first_char;

   // Pick keyword character number idx, counted from the start
   function automatic logic [7:0] kw_char(input dfa_state_t idx);
      logic [8*KEYWORD_LEN-1:0] shifted;
      shifted = KEYWORD >> (8 * (KEYWORD_LEN - 1 - int'(idx)));
      return shifted[7:0];
   endfunction

   assign next_char  = kw_char(state);
   assign first_char = kw_char('0);

   // Saved state goes back out for the per-stream memory
   assign state_out = state;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state  <= '0;
         accept <= 1'b0;
      end
      else
      begin
         // Accept lasts a single cycle
         accept <= 1'b0;

         // Restore from outside wins, no byte arrives in that cycle anyway
         if (state_in_vld)
         begin
            state <= state_in;
         end
         else if (char_vld)
         begin
            if (char_in == next_char)
            begin
               // Full keyword seen, pulse and start over
               if (state == LAST_IDX)
               begin
                  state  <= '0;
                  accept <= 1'b1;
               end
               else
               begin
                  state <= state + dfa_state_t'(1);
               end
            end
            // Mismatch, the byte may still open a new match
            // Exact because keywords do not overlap themselves
            else if (char_in == first_char)
            begin
               state <= dfa_state_t'(1);
            end
            else
            begin
               state <= '0;
            end
         end
      end
   end

endmodule

/* hw/category_tracker.sv */
`timescale 1ns/1ps

module category_tracker #(
   // Number of streams with saved matcher state
   parameter int                      STREAMS     = 64,
   // Keyword of this category
   parameter int                      KEYWORD_LEN = 7,
   parameter logic [8*KEYWORD_LEN-1:0] KEYWORD    = "ARTICLE"
) (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   load_state,
   input  logic                                   new_stream,
   input  logic [pkt_classifier_pkg::STREAM_W-1:0] cur_stream,
   input  logic                                   enable,
   input  pkt_classifier_pkg::pkt_beat_t          beat,
   output logic [pkt_classifier_pkg::COUNT_W-1:0]  count,
   output logic                                   fired
);

   typedef logic [pkt_classifier_pkg::DFA_STATE_W-1:0] dfa_state_t;
   typedef logic [pkt_classifier_pkg::COUNT_W-1:0]     count_t;

   // Saved matched length per stream
   dfa_state_t state_mem [STREAMS];

   // Restore path into the matcher
   dfa_state_t state_in;
   logic       state_in_vld;

   // Matcher outputs
   dfa_state_t state_out;
   logic       accept;

   // Set by any match in the current packet
   logic       spec_match;

   assign fired = spec_match;

   keyword_dfa #(
      .KEYWORD_LEN (KEYWORD_LEN),
      .KEYWORD     (KEYWORD)
   ) dfa0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (beat.char_in),
      .char_vld     (beat.char_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept       (accept)
   );

   // Match flag and fired-packet count
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count      <= '0;
         spec_match <= 1'b0;
      end
      else
      begin
         // New packet starts with a clean flag
         if (load_state)
         begin
            spec_match <= 1'b0;
         end

         if (accept)
         begin
            spec_match <= 1'b1;
         end

         // Close the packet
         if (beat.eop)
         begin
            if (enable)
            begin
               // Adds one at most, however many matches the packet had
               count <= count + count_t'(spec_match);
            end
            else
            begin
               // Category is off for this stream, drop the result
               spec_match <= 1'b0;
            end
         end
      end
   end

   // Per-stream state memory
   // A stream seen for the first time gets a zero entry,
   // so a later packet with the category off still restores zero
   always_ff @(posedge clk)
   begin
      if (load_state && new_stream)
      begin
         state_mem[cur_stream] <= '0;
      end
      else if (beat.eop && enable)
      begin
         state_mem[cur_stream] <= state_out;
      end
   end

   // Present the restore value one cycle after load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_in_vld <= 1'b0;
      end
      else
      begin
         state_in_vld <= load_state;
      end
   end

   // Zero for a fresh stream, otherwise the saved entry
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         state_in <= new_stream ? dfa_state_t'(0) : state_mem[cur_stream];
      end
   end

endmodule

/* hw/stream_table.sv */
`timescale 1ns/1ps

module stream_table #(
   // Number of stream entries
   parameter int STREAMS = 64
) (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  pkt_classifier_pkg::pkt_beat_t          beat,
   input  pkt_classifier_pkg::cfg_wr_t            cfg,
   output logic                                   load_state,
   output logic                                   new_stream,
   output logic [pkt_classifier_pkg::STREAM_W-1:0] cur_stream,
   output logic [pkt_classifier_pkg::NUM_CAT-1:0]  cur_enable
);

   // Stream has carried a packet since reset or its last rewrite
   logic [STREAMS-1:0] seen;

   // Category enables per stream
   logic [STREAMS-1:0][pkt_classifier_pkg::NUM_CAT-1:0] mask;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         seen       <= '0;
         // Every category starts enabled on every stream
         mask       <= '1;
         load_state <= 1'b0;
         new_stream <= 1'b0;
         cur_stream <= '0;
         cur_enable <= '0;
      end
      else
      begin
         // Restore pulse follows sop by one cycle
         load_state <= beat.sop;

         // Rewrite of an entry
         // Clearing seen makes the next packet start both matchers from zero
         if (cfg.we)
         begin
            mask[cfg.stream] <= cfg.enable;
            seen[cfg.stream] <= 1'b0;
         end

         // Packet start, latch stream and its enables until the next sop
         if (beat.sop)
         begin
            cur_stream           <= beat.stream_id;
            cur_enable           <= mask[beat.stream_id];
            new_stream           <= !seen[beat.stream_id];
            seen[beat.stream_id] <= 1'b1;
         end
      end
   end

endmodule

/* hw/pkt_classifier_top.sv */
`timescale 1ns/1ps

module pkt_classifier_top #(
   // Streams held in the tables
   parameter int               STREAMS      = pkt_classifier_pkg::NUM_STREAMS,
   // NNTP keyword, category 0
   parameter int               NNTP_LEN     = 7,
   parameter logic [8*NNTP_LEN-1:0] NNTP_KEYWORD = "ARTICLE",
   // SMTP keyword, category 1
   parameter int               SMTP_LEN     = 4,
   parameter logic [8*SMTP_LEN-1:0] SMTP_KEYWORD = "HELO"
) (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  pkt_classifier_pkg::pkt_beat_t         beat,
   input  pkt_classifier_pkg::cfg_wr_t           cfg,
   output logic [pkt_classifier_pkg::NUM_CAT-1:0][pkt_classifier_pkg::COUNT_W-1:0] count,
   output logic [pkt_classifier_pkg::NUM_CAT-1:0] fired
);

   // Packet context shared by both categories
   logic                                   load_state;
   logic                                   new_stream;
   logic [pkt_classifier_pkg::STREAM_W-1:0] cur_stream;
   logic [pkt_classifier_pkg::NUM_CAT-1:0]  cur_enable;

   stream_table #(
      .STREAMS (STREAMS)
   ) table0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .beat       (beat),
      .cfg        (cfg),
      .load_state (load_state),
      .new_stream (new_stream),
      .cur_stream (cur_stream),
      .cur_enable (cur_enable)
   );

   // NNTP category
   category_tracker #(
      .STREAMS     (STREAMS),
      .KEYWORD_LEN (NNTP_LEN),
      .KEYWORD     (NNTP_KEYWORD)
   ) nntp0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_state (load_state),
      .new_stream (new_stream),
      .cur_stream (cur_stream),
      .enable     (cur_enable[0]),
      .beat       (beat),
      .count      (count[0]),
      .fired      (fired[0])
   );

   // SMTP category
   category_tracker #(
      .STREAMS     (STREAMS),
      .KEYWORD_LEN (SMTP_LEN),
      .KEYWORD     (SMTP_KEYWORD)
   ) smtp0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_state (load_state),
      .new_stream (new_stream),
      .cur_stream (cur_stream),
      .enable     (cur_enable[1]),
      .beat       (beat),
      .count      (count[1]),
      .fired      (fired[1])
   );

endmodule

/* verification/classifier_checker.sv */
`timescale 1ns/1ps

module classifier_checker (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  pkt_classifier_pkg::pkt_beat_t          beat,
   input  pkt_classifier_pkg::cfg_wr_t            cfg,
   input  logic [pkt_classifier_pkg::NUM_CAT-1:0][pkt_classifier_pkg::COUNT_W-1:0] count,
   input  logic [pkt_classifier_pkg::NUM_CAT-1:0] fired,
   output int                                     errors,
   output int                                     checks
);

   localparam int CATS    = pkt_classifier_pkg::NUM_CAT;
   localparam int STREAMS = pkt_classifier_pkg::NUM_STREAMS;

   // Stream table model
   bit [STREAMS-1:0]  seen;
   bit [CATS-1:0]     mask [STREAMS];
   int                cur;
   bit [CATS-1:0]     cur_en;

   // Matched length, live and saved per stream
   int                len [CATS];
   int                saved [CATS][STREAMS];

   // Expected outputs and their one-cycle pipeline steps
   bit [CATS-1:0]     exp_fired;
   logic [pkt_classifier_pkg::COUNT_W-1:0] exp_count [CATS];
   bit [CATS-1:0]     accept_pend;
   bit                clear_pend;
   bit                model_on;

   initial
   begin
      errors   = 0;
      checks   = 0;
      model_on = 1'b0;
   end

   // Keyword text of each category
   function automatic logic [7:0] key_char(input int cat, input int idx);
      string word;
      if (cat == 0)
         word = "ARTICLE";
      else
         word = "HELO";
      return word[idx];
   endfunction

   function automatic int key_len(input int cat);
      if (cat == 0)
         return 7;
      return 4;
   endfunction

   // Next matched length, hit on a complete keyword
   function automatic int step_len(input int cat, input int cur_len,
                                   input logic [7:0] ch, output bit hit);
      hit = 1'b0;
      if (ch == key_char(cat, cur_len))
      begin
         if (cur_len + 1 == key_len(cat))
         begin
            hit = 1'b1;
            return 0;
         end
         return cur_len + 1;
      end
      // A mismatching byte may open a new match
      if (ch == key_char(cat, 0))
         return 1;
      return 0;
   endfunction

   // Model advances on the same edge as the DUT
   always @(posedge clk)
   begin : model
      bit old_fired;
      bit hit;
      if (!rst_n)
      begin
         seen        = '0;
         cur         = 0;
         cur_en      = '0;
         exp_fired   = '0;
         accept_pend = '0;
         clear_pend  = 1'b0;
         for (int c = 0; c < CATS; c++)
         begin
            len[c]       = 0;
            exp_count[c] = '0;
         end
         for (int s = 0; s < STREAMS; s++)
         begin
            mask[s] = '1;
            for (int c = 0; c < CATS; c++)
               saved[c][s] = 0;
         end
         model_on = 1'b1;
      end
      else
      begin
         for (int c = 0; c < CATS; c++)
         begin
            old_fired = exp_fired[c];
            // Clear one cycle after the load pulse
            if (clear_pend)
               exp_fired[c] = 1'b0;
            // Accept reaches fired one cycle late
            if (accept_pend[c])
               exp_fired[c] = 1'b1;
            accept_pend[c] = 1'b0;
            if (beat.eop)
            begin
               if (cur_en[c])
               begin
                  exp_count[c] = exp_count[c] + old_fired;
                  saved[c][cur] = len[c];
               end
               else
               begin
                  exp_fired[c] = 1'b0;
               end
            end
            if (beat.char_vld)
            begin
               len[c]         = step_len(c, len[c], beat.char_in, hit);
               accept_pend[c] = hit;
            end
         end
         clear_pend = beat.sop;
         // New packet restores saved length, or zero for a fresh stream
         if (beat.sop)
         begin
            cur    = beat.stream_id;
            cur_en = mask[cur];
            for (int c = 0; c < CATS; c++)
            begin
               if (!seen[cur])
                  saved[c][cur] = 0;
               len[c] = saved[c][cur];
            end
            seen[cur] = 1'b1;
         end
         if (cfg.we)
         begin
            mask[cfg.stream] = cfg.enable;
            seen[cfg.stream] = 1'b0;
         end
      end
   end

   // DUT outputs are settled by the falling edge
   always @(negedge clk)
   begin
      if (model_on)
      begin
         for (int c = 0; c < CATS; c++)
         begin
            checks = checks + 2;
            if (fired[c] !== exp_fired[c])
            begin
               $display("Fail fired[%0d] at %0t: expected %h, actual %h",
                        c, $time, exp_fired[c], fired[c]);
               errors++;
            end
            if (count[c] !== exp_count[c])
            begin
               $display("Fail count[%0d] at %0t: expected %h, actual %h",
                        c, $time, exp_count[c], count[c]);
               errors++;
            end
         end
      end
   end

endmodule

/* verification/tb_pkt_classifier.sv */
`timescale 1ns/1ps

module tb_pkt_classifier;

   logic                                   clk;
   logic                                   rst_n;
   pkt_classifier_pkg::pkt_beat_t          beat;
   pkt_classifier_pkg::cfg_wr_t            cfg;
   logic [pkt_classifier_pkg::NUM_CAT-1:0][pkt_classifier_pkg::COUNT_W-1:0] count;
   logic [pkt_classifier_pkg::NUM_CAT-1:0] fired;

   // Mismatches seen by the checker
   int  compare_errors;
   int  compare_count;
   // Waits that ran out
   int  timeouts;
   int  seed;
   // Bytes of the next packet
   byte payload [$];

   // 8 ns clock
   always #4 clk = ~clk;

   pkt_classifier_top dut0 (
      .clk   (clk),
      .rst_n (rst_n),
      .beat  (beat),
      .cfg   (cfg),
      .count (count),
      .fired (fired)
   );

   classifier_checker chk0 (
      .clk    (clk),
      .rst_n  (rst_n),
      .beat   (beat),
      .cfg    (cfg),
      .count  (count),
      .fired  (fired),
      .errors (compare_errors),
      .checks (compare_count)
   );

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // Small stream set so that streams recur
   function automatic logic [pkt_classifier_pkg::STREAM_W-1:0] pick_stream();
      int r;
      r = rand_below(6);
      return r[pkt_classifier_pkg::STREAM_W-1:0];
   endfunction

   // Mostly keyword letters and now and then any capital
   function automatic byte pick_char();
      logic [8*11-1:0] letters;
      letters = "ARTICLEHELO";
      if (rand_below(4) == 0)
         return byte'(8'h41 + rand_below(26));
      return letters[8*rand_below(11) +: 8];
   endfunction

   // Beat is applied 1 ns after the edge and held for one clock
   task automatic put(input pkt_classifier_pkg::pkt_beat_t b);
      beat = b;
      @(posedge clk);
      #1;
   endtask

   task automatic idle(input int n);
      repeat (n) put('0);
   endtask

   task automatic set_text(input string s);
      payload.delete();
      for (int k = 0; k < s.len(); k++)
         payload.push_back(s[k]);
   endtask

   task automatic random_payload();
      int n;
      payload.delete();
      n = rand_below(13);
      repeat (n) payload.push_back(pick_char());
   endtask

   // Config beat sits in an idle packet cycle
   task automatic write_cfg(input logic [pkt_classifier_pkg::STREAM_W-1:0] stream,
                            input logic [pkt_classifier_pkg::NUM_CAT-1:0] en);
      cfg.we     = 1'b1;
      cfg.stream = stream;
      cfg.enable = en;
      put('0);
      cfg = '0;
   endtask

   // One packet with the minimum spacing plus random gaps when asked
   // want lists categories that must fire before eop
   task automatic send_packet(input logic [pkt_classifier_pkg::STREAM_W-1:0] stream,
                              input logic [pkt_classifier_pkg::NUM_CAT-1:0] want,
                              input bit gaps);
      pkt_classifier_pkg::pkt_beat_t b;
      int t;
      b           = '0;
      b.sop       = 1'b1;
      b.stream_id = stream;
      put(b);
      // Two cycles for the state restore
      idle(2 + (gaps ? rand_below(3) : 0));
      for (int k = 0; k < payload.size(); k++)
      begin
         b          = '0;
         b.char_vld = 1'b1;
         b.char_in  = payload[k];
         put(b);
         if (gaps && rand_below(4) == 0)
            idle(1 + rand_below(2));
      end
      // Fired has to show up before the packet closes
      t = 0;
      while ((fired & want) != want && t < 8)
      begin
         idle(1);
         t++;
      end
      if ((fired & want) != want)
      begin
         $display("Timeout: fired never rose for stream %0d at %0t", stream, $time);
         timeouts++;
      end
      // Two cycles for accept to reach fired
      idle(2 + (gaps ? rand_below(3) : 0));
      b     = '0;
      b.eop = 1'b1;
      put(b);
      idle(1 + (gaps ? rand_below(3) : 0));
   endtask

   initial
   begin
      int r;
      clk      = 1'b0;
      rst_n    = 1'b0;
      beat     = '0;
      cfg      = '0;
      timeouts = 0;
      seed     = 32'hab495c68;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      idle(2);

      // Restart on mismatch for both categories in one packet
      set_text("HEHELOARTARTICLE");
      send_packet(6'd1, 2'b11, 1'b0);
      // Two hits in one packet still count once
      set_text("ARTICLEXARTICLE");
      send_packet(6'd1, 2'b01, 1'b0);

      // Keywords split over packets with other streams between
      set_text("ARTI");
      send_packet(6'd2, 2'b00, 1'b0);
      set_text("HEL");
      send_packet(6'd3, 2'b00, 1'b0);
      set_text("XYZ");
      send_packet(6'd4, 2'b00, 1'b0);
      set_text("CLE");
      send_packet(6'd2, 2'b01, 1'b0);
      set_text("O");
      send_packet(6'd3, 2'b10, 1'b0);

      // Rewrite drops the leftover partial match
      set_text("ARTIC");
      send_packet(6'd2, 2'b00, 1'b0);
      write_cfg(6'd2, 2'b11);
      set_text("LE");
      send_packet(6'd2, 2'b00, 1'b0);

      // SMTP off on stream 3 so fired rises but nothing is counted
      write_cfg(6'd3, 2'b01);
      set_text("HELO");
      send_packet(6'd3, 2'b10, 1'b0);
      // Partial SMTP match of a disabled packet is not saved
      set_text("HEL");
      send_packet(6'd3, 2'b00, 1'b0);
      // NNTP stays on and keeps its partial match
      set_text("OARTI");
      send_packet(6'd3, 2'b00, 1'b0);
      // Re-enabling restarts both matchers from zero
      write_cfg(6'd3, 2'b11);
      set_text("CLEHEL");
      send_packet(6'd3, 2'b00, 1'b0);
      // SMTP saves and counts again
      set_text("O");
      send_packet(6'd3, 2'b10, 1'b0);

      // Random traffic with occasional table rewrites
      for (int n = 0; n < 400; n++)
      begin
         random_payload();
         send_packet(pick_stream(), 2'b00, 1'b1);
         if (rand_below(8) == 0)
         begin
            r = rand_below(4);
            write_cfg(pick_stream(), r[1:0]);
         end
      end
      idle(4);

      $display("Errors: compare %0d, timeout %0d, checks %0d",
               compare_errors, timeouts, compare_count);
      if (compare_errors == 0 && timeouts == 0)
      begin
         $display("Simulation PASSED");
      end
      else
      begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* sim.f */
hw/pkt_classifier_pkg.sv
hw/keyword_dfa.sv
hw/category_tracker.sv
hw/stream_table.sv
hw/pkt_classifier_top.sv
verification/classifier_checker.sv
verification/tb_pkt_classifier.sv
